//--- Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

SOURCES := $(wildcard hw/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
+incdir+sim
hw/decode_pkg.sv
hw/lane_ctrl_if.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/dispatch_pack.sv
hw/decode_stage.sv
sim/tb_decode_stage.sv

//--- hw/decode_pkg.sv
package decode_pkg;

    localparam int NUM_LANES = 2;
    localparam int XLEN      = 32;
    localparam int ARN_WIDTH = 5;

    typedef logic [XLEN-1:0]      inst_t;
    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [XLEN-1:0]      data_t;
    typedef logic [ARN_WIDTH-1:0] arn_t;

    // x0 also stands in for an operand that is not read
    localparam arn_t ZERO_REG = '0;

    // major opcodes in inst[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam inst_t WFI_INST = 32'h1050_0073;

    typedef enum logic [2:0] {
        FU_ALU,
        FU_MULT,    // reserved for M extension
        FU_LOAD,
        FU_STORE,
        FU_BRANCH,
        FU_CSR,
        FU_NONE
    } fu_type_e;

    // {funct7[5], funct3} for alu and branch ops
    typedef logic [3:0] fu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_e;

    typedef enum logic [1:0] {
        OPB_IS_RS2,
        OPB_IS_IMM,
        OPB_IS_FOUR
    } opb_sel_e;

    // load/store funct3 gives width and sign
    typedef logic [2:0] mem_func_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_fmt_e;

endpackage

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    // fetch side
    input  logic      in_valid,
    output logic      in_ready,
    input  logic      in_lane_valid     [NUM_LANES],
    input  inst_t     in_inst           [NUM_LANES],
    input  addr_t     in_pc             [NUM_LANES],
    // dispatch side
    output logic      out_valid,
    input  logic      out_ready,
    output logic      out_lane_valid    [NUM_LANES],
    output fu_type_e  out_fu            [NUM_LANES],
    output fu_func_t  out_func          [NUM_LANES],
    output opa_sel_e  out_opa_sel       [NUM_LANES],
    output opb_sel_e  out_opb_sel       [NUM_LANES],
    output arn_t      out_op1_arn       [NUM_LANES],
    output arn_t      out_op2_arn       [NUM_LANES],
    output arn_t      out_dest_arn      [NUM_LANES],
    output data_t     out_imm           [NUM_LANES],
    output addr_t     out_pc            [NUM_LANES],
    output mem_func_t out_mem_func      [NUM_LANES],
    output logic      out_cond_branch   [NUM_LANES],
    output logic      out_uncond_branch [NUM_LANES],
    output logic      out_is_store      [NUM_LANES],
    output logic      out_rd_mem        [NUM_LANES],
    output logic      out_halt          [NUM_LANES],
    output logic      out_csr_op        [NUM_LANES],
    output logic      out_illegal       [NUM_LANES]
);

    logic load;

    // register empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_ctrl_if ctrl ();
        data_t imm;
        arn_t  op1_arn;
        arn_t  op2_arn;
        arn_t  dest_arn;
        logic  is_store;

        inst_decoder u_decoder (
            .inst  (in_inst[i]),
            .valid (in_lane_valid[i]),
            .ctrl  (ctrl.decoder)
        );

        imm_gen u_imm_gen (
            .inst (in_inst[i]),
            .fmt  (ctrl.imm_fmt),
            .imm  (imm)
        );

        dispatch_pack u_pack (
            .ctrl     (ctrl.packer),
            .inst     (in_inst[i]),
            .imm      (imm),
            .op1_arn  (op1_arn),
            .op2_arn  (op2_arn),
            .dest_arn (dest_arn),
            .is_store (is_store)
        );

        always_ff @(posedge clock) begin
            if (load) begin
                out_lane_valid[i]    <= in_lane_valid[i];
                out_pc[i]            <= in_pc[i];
                out_fu[i]            <= ctrl.fu;
                out_func[i]          <= ctrl.func;
                out_opa_sel[i]       <= ctrl.opa_sel;
                out_opb_sel[i]       <= ctrl.opb_sel;
                out_op1_arn[i]       <= op1_arn;
                out_op2_arn[i]       <= op2_arn;
                out_dest_arn[i]      <= dest_arn;
                out_imm[i]           <= imm;
                out_mem_func[i]      <= ctrl.mem_func;
                out_cond_branch[i]   <= ctrl.cond_branch;
                out_uncond_branch[i] <= ctrl.uncond_branch;
                out_is_store[i]      <= is_store;
                out_rd_mem[i]        <= ctrl.rd_mem;
                out_halt[i]          <= ctrl.halt;
                out_csr_op[i]        <= ctrl.csr_op;
                out_illegal[i]       <= ctrl.illegal;
            end
        end

        // stalled record must not change under the consumer
        assert property (@(posedge clock) disable iff (!rst_n)
            out_valid && !out_ready |=> out_valid && $stable({
                out_lane_valid[i], out_pc[i], out_fu[i], out_func[i],
                out_opa_sel[i], out_opb_sel[i], out_op1_arn[i], out_op2_arn[i],
                out_dest_arn[i], out_imm[i], out_mem_func[i], out_cond_branch[i],
                out_uncond_branch[i], out_is_store[i], out_rd_mem[i], out_halt[i],
                out_csr_op[i], out_illegal[i]}))
            else $error("lane %0d output changed while stalled", i);
    end

endmodule

//--- hw/dispatch_pack.sv
`timescale 1ns/1ps

module dispatch_pack
    import decode_pkg::*;
(
    lane_ctrl_if.packer ctrl,
    input  inst_t       inst,
    input  data_t       imm,
    output arn_t        op1_arn,
    output arn_t        op2_arn,
    output arn_t        dest_arn,
    output logic        is_store
);

    arn_t rs1;
    arn_t rs2;
    arn_t rd;
    logic use_rs1;
    logic use_rs2;

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    assign is_store = (ctrl.fu == FU_STORE);

    // branches compare rs1/rs2 while the alu ports hold pc and offset
    assign use_rs1 = !ctrl.halt && (ctrl.opa_sel == OPA_IS_RS1 || ctrl.cond_branch);
    // store data rides on rs2 although operand b is the offset
    assign use_rs2 = !ctrl.halt &&
                     (ctrl.opb_sel == OPB_IS_RS2 || ctrl.cond_branch || is_store);

    assign op1_arn  = use_rs1 ? rs1 : ZERO_REG;
    assign op2_arn  = use_rs2 ? rs2 : ZERO_REG;
    assign dest_arn = ctrl.has_dest ? rd : ZERO_REG;

    always_comb begin
        assert (!(ctrl.illegal && is_store))
            else $error("illegal lane marked as store");
        // store queue entry and fu class must agree
        assert (is_store == ctrl.wr_mem)
            else $error("store class and memory write disagree");
        // pc-relative offsets are halfword aligned
        assert (!(ctrl.imm_fmt inside {IMM_B, IMM_J}) || imm[0] == 1'b0)
            else $error("branch offset not halfword aligned");
        assert (ctrl.imm_fmt != IMM_NONE || imm == '0)
            else $error("immediate present on a format without one");
    end

endmodule

//--- hw/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
    import decode_pkg::*;
(
    input  inst_t    inst,
    input  imm_fmt_e fmt,
    output data_t    imm
);

    logic sign;

    // every format takes its sign from bit 31
    assign sign = inst[31];

    always_comb begin
        case (fmt)
            IMM_I: begin
                imm = {{(XLEN-12){sign}}, inst[31:20]};
            end
            IMM_S: begin
                imm = {{(XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                // halfword offset with bit 0 implied
                imm = {{(XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{(XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import decode_pkg::*;
(
    input  inst_t        inst,
    input  logic         valid,
    lane_ctrl_if.decoder ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       reg_ok;
    logic       shift_ok;
    logic       load_ok;
    logic       store_ok;
    logic       branch_ok;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // sub/sra are the only alternate encodings
    assign reg_ok = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign shift_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                      (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                      1'b1;
    assign load_ok   = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    assign store_ok  = funct3 inside {3'b000, 3'b001, 3'b010};
    assign branch_ok = !(funct3 inside {3'b010, 3'b011});

    always_comb begin
        // inactive lane has no sources, no dest and a zero immediate
        ctrl.opa_sel       = OPA_IS_ZERO;
        ctrl.opb_sel       = OPB_IS_IMM;
        ctrl.has_dest      = 1'b0;
        ctrl.fu            = FU_NONE;
        ctrl.func          = '0;
        ctrl.cond_branch   = 1'b0;
        ctrl.uncond_branch = 1'b0;
        ctrl.rd_mem        = 1'b0;
        ctrl.wr_mem        = 1'b0;
        ctrl.mem_func      = '0;
        ctrl.csr_op        = 1'b0;
        ctrl.halt          = 1'b0;
        ctrl.illegal       = 1'b0;
        ctrl.imm_fmt       = IMM_NONE;
        if (valid) begin
            case (opcode)
                OP_LUI: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.fu       = FU_ALU;
                    ctrl.imm_fmt  = IMM_U;
                end
                OP_AUIPC: begin
                    ctrl.opa_sel  = OPA_IS_PC;
                    ctrl.has_dest = 1'b1;
                    ctrl.fu       = FU_ALU;
                    ctrl.imm_fmt  = IMM_U;
                end
                OP_JAL: begin
                    // link value is pc + 4, target comes from the J immediate
                    ctrl.opa_sel       = OPA_IS_PC;
                    ctrl.opb_sel       = OPB_IS_FOUR;
                    ctrl.has_dest      = 1'b1;
                    ctrl.fu            = FU_BRANCH;
                    ctrl.uncond_branch = 1'b1;
                    ctrl.imm_fmt       = IMM_J;
                end
                OP_JALR: begin
                    if (funct3 == 3'b000) begin
                        ctrl.opa_sel       = OPA_IS_RS1;
                        ctrl.has_dest      = 1'b1;
                        ctrl.fu            = FU_BRANCH;
                        ctrl.uncond_branch = 1'b1;
                        ctrl.imm_fmt       = IMM_I;
                    end else begin
                        ctrl.illegal = 1'b1;
                    end
                end
                OP_BRANCH: begin
                    if (branch_ok) begin
                        ctrl.opa_sel     = OPA_IS_PC;
                        ctrl.fu          = FU_BRANCH;
                        ctrl.func        = {funct7[5], funct3};
                        ctrl.cond_branch = 1'b1;
                        ctrl.imm_fmt     = IMM_B;
                    end else begin
                        ctrl.illegal = 1'b1;
                    end
                end
                OP_LOAD: begin
                    if (load_ok) begin
                        ctrl.opa_sel  = OPA_IS_RS1;
                        ctrl.has_dest = 1'b1;
                        ctrl.fu       = FU_LOAD;
                        ctrl.rd_mem   = 1'b1;
                        ctrl.mem_func = funct3;
                        ctrl.imm_fmt  = IMM_I;
                    end else begin
                        ctrl.illegal = 1'b1;
                    end
                end
                OP_STORE: begin
                    if (store_ok) begin
                        ctrl.opa_sel  = OPA_IS_RS1;
                        ctrl.fu       = FU_STORE;
                        ctrl.wr_mem   = 1'b1;
                        ctrl.mem_func = funct3;
                        ctrl.imm_fmt  = IMM_S;
                    end else begin
                        ctrl.illegal = 1'b1;
                    end
                end
                OP_IMM: begin
                    if (shift_ok) begin
                        ctrl.opa_sel  = OPA_IS_RS1;
                        ctrl.has_dest = 1'b1;
                        ctrl.fu       = FU_ALU;
                        // bit 30 only means srai, otherwise it is immediate
                        ctrl.func     = {(funct3[1:0] == 2'b01) && funct7[5], funct3};
                        ctrl.imm_fmt  = IMM_I;
                    end else begin
                        ctrl.illegal = 1'b1;
                    end
                end
                OP_REG: begin
                    if (reg_ok) begin
                        ctrl.opa_sel  = OPA_IS_RS1;
                        ctrl.opb_sel  = OPB_IS_RS2;
                        ctrl.has_dest = 1'b1;
                        ctrl.fu       = FU_ALU;
                        ctrl.func     = {funct7[5], funct3};
                    end else begin
                        ctrl.illegal = 1'b1;
                    end
                end
                OP_SYSTEM: begin
                    if (inst == WFI_INST) begin
                        ctrl.halt = 1'b1;
                    end else if (funct3 != 3'b000 && funct3 != 3'b100) begin
                        // immediate forms carry a zimm in the rs1 field
                        ctrl.opa_sel  = funct3[2] ? OPA_IS_ZERO : OPA_IS_RS1;
                        ctrl.has_dest = 1'b1;
                        ctrl.fu       = FU_CSR;
                        ctrl.func     = {1'b0, funct3};
                        ctrl.csr_op   = 1'b1;
                        ctrl.imm_fmt  = IMM_I;
                    end else begin
                        // ecall, ebreak, xret trap as illegal
                        ctrl.illegal = 1'b1;
                    end
                end
                default: ctrl.illegal = 1'b1;
            endcase
        end
    end

    always_comb begin
        assert (!(ctrl.rd_mem && ctrl.wr_mem))
            else $error("lane decoded as both load and store");
    end

endmodule

//--- hw/lane_ctrl_if.sv
`timescale 1ns/1ps

interface lane_ctrl_if
    import decode_pkg::*;
();

    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    logic      has_dest;
    fu_type_e  fu;
    fu_func_t  func;
    logic      cond_branch;
    logic      uncond_branch;
    logic      rd_mem;
    logic      wr_mem;
    mem_func_t mem_func;
    logic      csr_op;
    logic      halt;
    logic      illegal;
    imm_fmt_e  imm_fmt;

    modport decoder (
        output opa_sel, opb_sel, has_dest, fu, func, cond_branch, uncond_branch,
        output rd_mem, wr_mem, mem_func, csr_op, halt, illegal, imm_fmt
    );

    modport packer (
        input opa_sel, opb_sel, has_dest, fu, func, cond_branch, uncond_branch,
        input rd_mem, wr_mem, mem_func, csr_op, halt, illegal, imm_fmt
    );

endinterface

//--- sim/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// {func, opa, opb, mem_func, cond, uncond, store, rd_mem, halt, csr, illegal}
typedef logic [17:0] ctrl_vec_t;

typedef struct packed {
    logic      lane_valid;
    addr_t     pc;
    fu_type_e  fu;
    arn_t      op1;
    arn_t      op2;
    arn_t      dest;
    data_t     imm;
    ctrl_vec_t ctrl;
} lane_rec_t;

typedef lane_rec_t [NUM_LANES-1:0] bundle_t;

function automatic data_t model_imm(inst_t inst, imm_fmt_e fmt);
    data_t imm;
    case (fmt)
        IMM_I:   imm = data_t'($signed(inst) >>> 20);
        IMM_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        IMM_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        IMM_U:   imm = {inst[31:12], 12'h000};
        IMM_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        default: imm = '0;
    endcase
    return imm;
endfunction

function automatic lane_rec_t model_lane(logic valid, inst_t inst, addr_t pc);
    lane_rec_t r;
    logic [2:0] f3;
    logic [6:0] f7;
    fu_type_e   fu;
    fu_func_t   func;
    opa_sel_e   opa;
    opb_sel_e   opb;
    mem_func_t  mf;
    imm_fmt_e   fmt;
    logic       has_dest;
    logic       cond;
    logic       uncond;
    logic       rd_mem;
    logic       halt;
    logic       csr;
    logic       illegal;
    logic       shift_legal;
    f3 = inst[14:12];
    f7 = inst[31:25];
    fu = FU_NONE;
    func = '0;
    opa = OPA_IS_ZERO;
    opb = OPB_IS_IMM;
    mf = '0;
    fmt = IMM_NONE;
    {has_dest, cond, uncond, rd_mem, halt, csr, illegal} = '0;
    shift_legal = (f3 == 3'b001) ? (f7 == 7'h00) :
                  (f3 == 3'b101) ? (f7 inside {7'h00, 7'h20}) : 1'b1;
    if (valid) begin
        case (inst[6:0])
            OP_LUI: begin
                {fu, has_dest, fmt} = {FU_ALU, 1'b1, IMM_U};
            end
            OP_AUIPC: begin
                {fu, opa, has_dest, fmt} = {FU_ALU, OPA_IS_PC, 1'b1, IMM_U};
            end
            OP_JAL: begin
                {fu, opa, opb, fmt} = {FU_BRANCH, OPA_IS_PC, OPB_IS_FOUR, IMM_J};
                {has_dest, uncond} = 2'b11;
            end
            OP_JALR: begin
                if (f3 == 3'b000) begin
                    {fu, opa, fmt} = {FU_BRANCH, OPA_IS_RS1, IMM_I};
                    {has_dest, uncond} = 2'b11;
                end else illegal = 1'b1;
            end
            OP_BRANCH: begin
                if (!(f3 inside {3'b010, 3'b011})) begin
                    {fu, opa, fmt, cond} = {FU_BRANCH, OPA_IS_PC, IMM_B, 1'b1};
                    func = {f7[5], f3};
                end else illegal = 1'b1;
            end
            OP_LOAD: begin
                if (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    {fu, opa, fmt, mf} = {FU_LOAD, OPA_IS_RS1, IMM_I, f3};
                    {has_dest, rd_mem} = 2'b11;
                end else illegal = 1'b1;
            end
            OP_STORE: begin
                if (f3 inside {3'b000, 3'b001, 3'b010}) begin
                    {fu, opa, fmt, mf} = {FU_STORE, OPA_IS_RS1, IMM_S, f3};
                end else illegal = 1'b1;
            end
            OP_IMM: begin
                if (shift_legal) begin
                    {fu, opa, fmt, has_dest} = {FU_ALU, OPA_IS_RS1, IMM_I, 1'b1};
                    // only srai keeps bit 30 as a function bit
                    func = {(f3 == 3'b101) && f7[5], f3};
                end else illegal = 1'b1;
            end
            OP_REG: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && f3 inside {3'b000, 3'b101})) begin
                    {fu, opa, opb, has_dest} = {FU_ALU, OPA_IS_RS1, OPB_IS_RS2, 1'b1};
                    func = {f7[5], f3};
                end else illegal = 1'b1;
            end
            OP_SYSTEM: begin
                if (inst == WFI_INST) begin
                    halt = 1'b1;
                end else if (f3 inside {3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111}) begin
                    {fu, fmt, func} = {FU_CSR, IMM_I, 1'b0, f3};
                    opa = f3[2] ? OPA_IS_ZERO : OPA_IS_RS1;
                    {has_dest, csr} = 2'b11;
                end else illegal = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end
    r.lane_valid = valid;
    r.pc = pc;
    r.fu = fu;
    r.dest = has_dest ? inst[11:7] : ZERO_REG;
    r.op1 = (!halt && (opa == OPA_IS_RS1 || cond)) ? inst[19:15] : ZERO_REG;
    r.op2 = (!halt && (opb == OPB_IS_RS2 || cond || fu == FU_STORE)) ? inst[24:20] : ZERO_REG;
    r.imm = model_imm(inst, fmt);
    r.ctrl = {func, opa, opb, mf, cond, uncond, fu == FU_STORE, rd_mem, halt, csr, illegal};
    return r;
endfunction

`endif

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage
    import decode_pkg::*;
();

    `include "decode_model.svh"

    localparam int NUM_BUNDLES = 2000;
    localparam int MAX_CYCLES  = NUM_BUNDLES * 4;

    logic      clock;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    logic      in_lane_valid     [NUM_LANES];
    inst_t     in_inst           [NUM_LANES];
    addr_t     in_pc             [NUM_LANES];
    logic      out_valid;
    logic      out_ready;
    logic      out_lane_valid    [NUM_LANES];
    fu_type_e  out_fu            [NUM_LANES];
    fu_func_t  out_func          [NUM_LANES];
    opa_sel_e  out_opa_sel       [NUM_LANES];
    opb_sel_e  out_opb_sel       [NUM_LANES];
    arn_t      out_op1_arn       [NUM_LANES];
    arn_t      out_op2_arn       [NUM_LANES];
    arn_t      out_dest_arn      [NUM_LANES];
    data_t     out_imm           [NUM_LANES];
    addr_t     out_pc            [NUM_LANES];
    mem_func_t out_mem_func      [NUM_LANES];
    logic      out_cond_branch   [NUM_LANES];
    logic      out_uncond_branch [NUM_LANES];
    logic      out_is_store      [NUM_LANES];
    logic      out_rd_mem        [NUM_LANES];
    logic      out_halt          [NUM_LANES];
    logic      out_csr_op        [NUM_LANES];
    logic      out_illegal       [NUM_LANES];

    bundle_t exp_q [$];
    bundle_t now_b;
    bundle_t snap;
    logic    stall_prev = 1'b0;
    logic    expect_out = 1'b0;
    int      issued = 0;
    int      n_in = 0;
    int      n_out = 0;
    int      cycles = 0;

    decode_stage dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic abort_run(string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_fu(string what, fu_type_e got, fu_type_e exp);
        if (got !== exp)
            abort_run($sformatf("Fail %0t: %s is %s, expected %s",
                                $time, what, got.name(), exp.name()));
    endtask

    task automatic check_arn(string what, arn_t got, arn_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %0t: %s is x%0d, expected x%0d", $time, what, got, exp));
    endtask

    task automatic check_data(string what, data_t got, data_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_ctrl(string what, ctrl_vec_t got, ctrl_vec_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic compare_bundle(bundle_t got, bundle_t exp);
        string tag;
        for (int i = 0; i < NUM_LANES; i++) begin
            tag = $sformatf("bundle %0d lane %0d", n_out, i);
            check_bit({tag, " lane_valid"}, got[i].lane_valid, exp[i].lane_valid);
            check_data({tag, " pc"}, got[i].pc, exp[i].pc);
            check_fu({tag, " fu"}, got[i].fu, exp[i].fu);
            check_ctrl({tag, " control"}, got[i].ctrl, exp[i].ctrl);
            check_arn({tag, " op1"}, got[i].op1, exp[i].op1);
            check_arn({tag, " op2"}, got[i].op2, exp[i].op2);
            check_arn({tag, " dest"}, got[i].dest, exp[i].dest);
            check_data({tag, " imm"}, got[i].imm, exp[i].imm);
        end
    endtask

    function automatic bundle_t read_bundle();
        bundle_t b;
        for (int i = 0; i < NUM_LANES; i++) begin
            b[i].lane_valid = out_lane_valid[i];
            b[i].pc = out_pc[i];
            b[i].fu = out_fu[i];
            b[i].op1 = out_op1_arn[i];
            b[i].op2 = out_op2_arn[i];
            b[i].dest = out_dest_arn[i];
            b[i].imm = out_imm[i];
            b[i].ctrl = {out_func[i], out_opa_sel[i], out_opb_sel[i], out_mem_func[i],
                         out_cond_branch[i], out_uncond_branch[i], out_is_store[i],
                         out_rd_mem[i], out_halt[i], out_csr_op[i], out_illegal[i]};
        end
        return b;
    endfunction

    function automatic bundle_t expected_bundle();
        bundle_t b;
        for (int i = 0; i < NUM_LANES; i++)
            b[i] = model_lane(in_lane_valid[i], in_inst[i], in_pc[i]);
        return b;
    endfunction

    // weighted mix of legal ops, wfi, csr and raw words
    function automatic inst_t random_inst();
        int unsigned pick;
        logic [2:0]  f3;
        inst_t       w;
        pick = $urandom % 100;
        w = $urandom;
        f3 = w[14:12];
        if (pick >= 85)
            return w;
        if (pick >= 75)
            return WFI_INST;
        if (pick >= 62) begin
            f3 = 3'(1 + $urandom % 3) | (w[0] ? 3'b100 : 3'b000);
            w[14:12] = f3;
            w[6:0] = OP_SYSTEM;
            return w;
        end
        case ($urandom % 9)
            0: w[6:0] = OP_LUI;
            1: w[6:0] = OP_AUIPC;
            2: w[6:0] = OP_JAL;
            3: {w[14:12], w[6:0]} = {3'b000, OP_JALR};
            4: begin
                if (f3[2:1] == 2'b01)
                    f3[1] = 1'b0;
                {w[14:12], w[6:0]} = {f3, OP_BRANCH};
            end
            5: begin
                if (f3[1:0] == 2'b11)
                    f3[1] = 1'b0;
                if (f3 == 3'b110)
                    f3 = 3'b100;
                {w[14:12], w[6:0]} = {f3, OP_LOAD};
            end
            6: {w[14:12], w[6:0]} = {3'($urandom % 3), OP_STORE};
            7: begin
                if (f3 == 3'b001 || (f3 == 3'b101 && !w[30]))
                    w[31:25] = 7'h00;
                else if (f3 == 3'b101)
                    w[31:25] = 7'h20;
                w[6:0] = OP_IMM;
            end
            default: begin
                w[31:25] = (w[30] && f3 inside {3'b000, 3'b101}) ? 7'h20 : 7'h00;
                w[6:0] = OP_REG;
            end
        endcase
        return w;
    endfunction

    always @(posedge clock) begin
        cycles++;
        if (cycles > MAX_CYCLES)
            abort_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end

    // sample between edges, where every output has settled
    always @(negedge clock) begin
        if (rst_n) begin
            now_b = read_bundle();
            // queue holds the one bundle the output register should carry
            check_bit("out_valid", out_valid, exp_q.size() != 0);
            check_bit("in_ready", in_ready, exp_q.size() == 0 || out_ready);
            if (stall_prev && now_b !== snap)
                abort_run($sformatf("Fail %0t: output changed while out_ready was low", $time));
            if (out_valid) begin
                compare_bundle(now_b, exp_q[0]);
                if (out_ready) begin
                    void'(exp_q.pop_front());
                    n_out++;
                end
            end
            stall_prev = out_valid && !out_ready;
            snap = now_b;
            expect_out = in_valid && in_ready;
            if (expect_out) begin
                exp_q.push_back(expected_bundle());
                n_in++;
            end
        end
    end

    initial begin
        void'($urandom(32'h2a5c_4374));
        rst_n = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            in_lane_valid[i] = 1'b0;
            in_inst[i] = '0;
            in_pc[i] = '0;
        end
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_bit("out_valid after reset", out_valid, 1'b0);
        check_bit("in_ready after reset", in_ready, 1'b1);

        while (n_in < NUM_BUNDLES) begin
            @(posedge clock);
            out_ready <= ($urandom % 4) != 0;
            // a pending bundle stays on the bus until taken
            if (!in_valid || expect_out) begin
                if (issued < NUM_BUNDLES && ($urandom % 4) != 0) begin
                    in_valid <= 1'b1;
                    for (int i = 0; i < NUM_LANES; i++) begin
                        in_lane_valid[i] <= ($urandom % 8) != 0;
                        in_inst[i] <= random_inst();
                        in_pc[i] <= $urandom & 32'hffff_fffc;
                    end
                    issued++;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end

        while (n_out < NUM_BUNDLES) begin
            @(posedge clock);
            out_ready <= ($urandom % 4) != 0;
        end
        @(negedge clock);
        check_bit("out_valid after drain", out_valid, 1'b0);
        if (exp_q.size() != 0) begin
            abort_run("bundles left over after the output drained");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
